// File: Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -j 0 --top-module rv_ex_tb -Mdir obj_dir -f compile.f
	./obj_dir/Vrv_ex_tb | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: compile.f
rv_ex_pkg.sv
rv_regfile.sv
rv_alu.sv
rv_branch_unit.sv
rv_ex_retire.sv
rv_ex_top.sv
rv_ex_asserts.sv
rv_ex_tb.sv

// File: rv_alu.sv
`timescale 1ns/1ns

module rv_alu (
    input  rv_ex_pkg::t_uinstr   uinstr,
    input  rv_ex_pkg::t_reg_data src1,
    input  rv_ex_pkg::t_reg_data src2,
    output rv_ex_pkg::t_reg_data alu_result
);

    rv_ex_pkg::t_reg_data opb;
    logic [4:0]           shamt;
    logic                 lt_signed;
    logic                 lt_unsigned;

    // ======================================================================
    // Operand select
    // ======================================================================

    always_comb begin
        if (uinstr.use_imm) begin
            opb = uinstr.imm32;
        end else begin
            opb = src2;
        end
    end

    // Only the low five bits count for RV32 shifts
    assign shamt = opb[4:0];

    assign lt_signed   = $signed(src1) < $signed(opb);
    assign lt_unsigned = src1 < opb;

    // ======================================================================
    // Operation
    // ======================================================================

    always_comb begin
        alu_result = '0;
        case (uinstr.alu_op)
            rv_ex_pkg::ALU_ADD: begin
                alu_result = src1 + opb;
            end
            rv_ex_pkg::ALU_SUB: begin
                alu_result = src1 - opb;
            end
            rv_ex_pkg::ALU_AND: begin
                alu_result = src1 & opb;
            end
            rv_ex_pkg::ALU_OR: begin
                alu_result = src1 | opb;
            end
            rv_ex_pkg::ALU_XOR: begin
                alu_result = src1 ^ opb;
            end
            rv_ex_pkg::ALU_SLL: begin
                alu_result = src1 << shamt;
            end
            rv_ex_pkg::ALU_SRL: begin
                alu_result = src1 >> shamt;
            end
            rv_ex_pkg::ALU_SRA: begin
                alu_result = $signed(src1) >>> shamt;
            end
            rv_ex_pkg::ALU_SLT: begin
                alu_result = {31'd0, lt_signed};
            end
            rv_ex_pkg::ALU_SLTU: begin
                alu_result = {31'd0, lt_unsigned};
            end
            default: begin
                alu_result = '0;
            end
        endcase
    end

endmodule

// File: rv_branch_unit.sv
`timescale 1ns/1ns

module rv_branch_unit (
    input  rv_ex_pkg::t_uinstr   uinstr,
    input  rv_ex_pkg::t_reg_data src1,
    input  rv_ex_pkg::t_reg_data src2,
    output logic                 br_resvld,
    output rv_ex_pkg::t_paddr    br_tgt,
    output logic                 br_mispred
);

    rv_ex_pkg::t_paddr pc_next;
    rv_ex_pkg::t_paddr tkn_tgt;
    logic              taken;

    assign br_resvld = uinstr.valid && (uinstr.uop == rv_ex_pkg::UOP_BR);

    // Predicted path is always the fall-through
    assign pc_next = uinstr.pc + 32'd4;
    assign tkn_tgt = uinstr.pc + uinstr.imm32;

    // ======================================================================
    // Condition evaluation
    // ======================================================================

    always_comb begin
        taken = 1'b0;
        case (uinstr.br_funct3)
            rv_ex_pkg::BR_BEQ: begin
                taken = src1 == src2;
            end
            rv_ex_pkg::BR_BNE: begin
                taken = src1 != src2;
            end
            rv_ex_pkg::BR_BLT: begin
                taken = $signed(src1) < $signed(src2);
            end
            rv_ex_pkg::BR_BGE: begin
                taken = $signed(src1) >= $signed(src2);
            end
            rv_ex_pkg::BR_BLTU: begin
                taken = src1 < src2;
            end
            rv_ex_pkg::BR_BGEU: begin
                taken = src1 >= src2;
            end
            default: begin
                taken = 1'b0;
            end
        endcase
    end

    // A taken branch with imm32 of 4 still lands on the fall-through
    assign br_tgt     = taken ? tkn_tgt : pc_next;
    assign br_mispred = br_resvld && (br_tgt != pc_next);

endmodule

// File: rv_ex_asserts.sv
`timescale 1ns/1ns

module rv_ex_asserts (
    input logic                 clk,
    input logic                 rst,
    input rv_ex_pkg::t_wb       wb,
    input rv_ex_pkg::t_redirect redirect
);

    // x0 is never a writeback target
    wb_rd_nonzero: assert property (@(posedge clk) disable iff (rst)
        wb.valid |-> wb.rd != 5'd0)
        else $error("wb.valid high with rd of zero");

    // A squashed follower can never redirect again
    redirect_single: assert property (@(posedge clk) disable iff (rst)
        redirect.valid |=> !redirect.valid)
        else $error("redirect.valid high in two consecutive cycles");

    reset_clears: assert property (@(posedge clk)
        rst |=> (!wb.valid && !redirect.valid))
        else $error("valid bits not cleared by reset");

endmodule

// File: rv_ex_pkg.sv
package rv_ex_pkg;

    // ======================================================================
    // Widths
    // ======================================================================

    localparam int XLEN      = 32;
    localparam int REG_IDX_W = 5;

    typedef logic [XLEN-1:0]      t_reg_data;
    typedef logic [XLEN-1:0]      t_paddr;
    typedef logic [REG_IDX_W-1:0] t_reg_idx;

    // ======================================================================
    // Micro-op encodings
    // ======================================================================

    // Execution unit select
    typedef enum logic [1:0] {
        UOP_ALU = 2'd0,
        UOP_BR  = 2'd1
    } t_uop;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } t_alu_op;

    // RISC-V conditional branch funct3 codes
    typedef enum logic [2:0] {
        BR_BEQ  = 3'b000,
        BR_BNE  = 3'b001,
        BR_BLT  = 3'b100,
        BR_BGE  = 3'b101,
        BR_BLTU = 3'b110,
        BR_BGEU = 3'b111
    } t_br_funct3;

    // ======================================================================
    // Records
    // ======================================================================

    // One decoded micro-op with valid as a single-cycle strobe
    typedef struct packed {
        logic       valid;
        t_uop       uop;
        t_alu_op    alu_op;
        t_br_funct3 br_funct3;
        t_reg_idx   rs1;
        t_reg_idx   rs2;
        t_reg_idx   rd;
        logic       use_imm;    // immediate replaces rs2 on the ALU
        t_reg_data  imm32;
        t_paddr     pc;
    } t_uinstr;

    typedef struct packed {
        logic      valid;
        t_reg_idx  rd;
        t_reg_data data;
    } t_wb;

    typedef struct packed {
        logic   valid;
        t_paddr pc;
    } t_redirect;

endpackage

// File: rv_ex_retire.sv
`timescale 1ns/1ns

module rv_ex_retire (
    input  logic                   clk,
    input  logic                   rst,

    input  rv_ex_pkg::t_uinstr     uinstr,
    input  rv_ex_pkg::t_reg_data   alu_result,
    input  logic                   br_resvld,
    input  logic                   br_mispred,
    input  rv_ex_pkg::t_paddr      br_tgt,

    output logic                   we,
    output rv_ex_pkg::t_reg_idx    wa,
    output rv_ex_pkg::t_reg_data   wd,

    output rv_ex_pkg::t_wb         wb,
    output rv_ex_pkg::t_redirect   redirect
);

    logic                 squash;
    logic                 live;
    logic                 redir_set;

    logic                 wb_valid_q;
    rv_ex_pkg::t_reg_idx  wb_rd_q;
    rv_ex_pkg::t_reg_data wb_data_q;
    logic                 redir_valid_q;
    rv_ex_pkg::t_paddr    redir_pc_q;

    // Wrong-path micro-op right after a mispredict is dropped here
    assign live      = uinstr.valid && !squash;
    assign redir_set = live && br_resvld && br_mispred;

    // Register file write in the same cycle as execute
    assign we = live && (uinstr.uop == rv_ex_pkg::UOP_ALU) && (uinstr.rd != '0);
    assign wa = uinstr.rd;
    assign wd = alu_result;

    // ======================================================================
    // Control state
    // ======================================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            squash        <= 1'b0;
            wb_valid_q    <= 1'b0;
            redir_valid_q <= 1'b0;
        end else begin
            squash        <= redir_set;
            wb_valid_q    <= we;
            redir_valid_q <= redir_set;
        end
    end

    // Payload only moves when a record is produced
    always_ff @(posedge clk) begin
        if (we) begin
            wb_rd_q   <= wa;
            wb_data_q <= wd;
        end
        if (redir_set) begin
            redir_pc_q <= br_tgt;
        end
    end

    assign wb       = '{valid: wb_valid_q, rd: wb_rd_q, data: wb_data_q};
    assign redirect = '{valid: redir_valid_q, pc: redir_pc_q};

endmodule

// File: rv_ex_tb.sv
`timescale 1ns/1ns

module rv_ex_tb;

    logic                 clk = 1'b0;
    logic                 rst = 1'b1;
    rv_ex_pkg::t_uinstr   uinstr = '0;
    rv_ex_pkg::t_wb       wb;
    rv_ex_pkg::t_redirect redirect;

    // Reference model state updated once per issued cycle
    logic [31:0]          model_regs [32];
    logic                 model_squash = 1'b0;
    rv_ex_pkg::t_wb       exp_wb = '0;
    rv_ex_pkg::t_redirect exp_redir = '0;
    logic [31:0]          rng = 32'd10;
    int                   errors = 0;

    rv_ex_top #(
        .num_regs (32)
    ) rv_ex_top_inst (
        .clk      (clk),
        .rst      (rst),
        .uinstr   (uinstr),
        .wb       (wb),
        .redirect (redirect)
    );

    bind rv_ex_top rv_ex_asserts rv_ex_asserts_inst (
        .clk      (clk),
        .rst      (rst),
        .wb       (wb),
        .redirect (redirect)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // ======================================================================
    // Reference model
    // ======================================================================

    function automatic logic [31:0] alu_model(input rv_ex_pkg::t_alu_op op,
                                              input logic [31:0] a, input logic [31:0] b);
        case (op)
            rv_ex_pkg::ALU_ADD:  return a + b;
            rv_ex_pkg::ALU_SUB:  return a - b;
            rv_ex_pkg::ALU_AND:  return a & b;
            rv_ex_pkg::ALU_OR:   return a | b;
            rv_ex_pkg::ALU_XOR:  return a ^ b;
            rv_ex_pkg::ALU_SLL:  return a << b[4:0];
            rv_ex_pkg::ALU_SRL:  return a >> b[4:0];
            rv_ex_pkg::ALU_SRA:  return $signed(a) >>> b[4:0];
            rv_ex_pkg::ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            rv_ex_pkg::ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            default:             return 32'd0;
        endcase
    endfunction

    function automatic logic branch_taken(input rv_ex_pkg::t_br_funct3 f,
                                          input logic [31:0] a, input logic [31:0] b);
        case (f)
            rv_ex_pkg::BR_BEQ:  return a == b;
            rv_ex_pkg::BR_BNE:  return a != b;
            rv_ex_pkg::BR_BLT:  return $signed(a) < $signed(b);
            rv_ex_pkg::BR_BGE:  return $signed(a) >= $signed(b);
            rv_ex_pkg::BR_BLTU: return a < b;
            rv_ex_pkg::BR_BGEU: return a >= b;
            default:            return 1'b0;
        endcase
    endfunction

    function automatic rv_ex_pkg::t_uinstr make_uop(input rv_ex_pkg::t_uop uop,
            input rv_ex_pkg::t_alu_op op, input rv_ex_pkg::t_br_funct3 f3,
            input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2,
            input logic use_imm, input logic [31:0] imm);
        rv_ex_pkg::t_uinstr u;
        u           = '0;
        u.valid     = 1'b1;
        u.uop       = uop;
        u.alu_op    = op;
        u.br_funct3 = f3;
        u.rd        = rd;
        u.rs1       = rs1;
        u.rs2       = rs2;
        u.use_imm   = use_imm;
        u.imm32     = imm;
        u.pc        = 32'h0000_1000 + {20'd0, rd, rs1, 2'b00};
        return u;
    endfunction

    task automatic check(input string name, input logic [31:0] act, input logic [31:0] exp);
        if (act !== exp) begin
            $display("ERR %s actual=%h expected=%h", name, act, exp);
            errors++;
        end
    endtask

    // Drive one micro-op, check the previous one, then predict this one
    task automatic issue(input rv_ex_pkg::t_uinstr u);
        logic [31:0] a;
        logic [31:0] b;
        @(posedge clk);
        uinstr <= u;
        @(negedge clk);
        check("wb.valid", 32'(wb.valid), 32'(exp_wb.valid));
        if (exp_wb.valid) begin
            check("wb.rd", 32'(wb.rd), 32'(exp_wb.rd));
            check("wb.data", wb.data, exp_wb.data);
        end
        check("redirect.valid", 32'(redirect.valid), 32'(exp_redir.valid));
        if (exp_redir.valid) begin
            check("redirect.pc", redirect.pc, exp_redir.pc);
        end
        a         = model_regs[u.rs1];
        b         = model_regs[u.rs2];
        exp_wb    = '0;
        exp_redir = '0;
        if (u.valid && !model_squash) begin
            if (u.uop == rv_ex_pkg::UOP_ALU && u.rd != 5'd0) begin
                exp_wb.valid = 1'b1;
                exp_wb.rd    = u.rd;
                exp_wb.data  = alu_model(u.alu_op, a, u.use_imm ? u.imm32 : b);
                model_regs[u.rd] = exp_wb.data;
            end else if (u.uop == rv_ex_pkg::UOP_BR) begin
                if (branch_taken(u.br_funct3, a, b) && u.imm32 != 32'd4) begin
                    exp_redir.valid = 1'b1;
                    exp_redir.pc    = u.pc + u.imm32;
                end
            end
        end
        model_squash = exp_redir.valid;
    endtask

    task automatic load_reg(input logic [4:0] rd, input logic [31:0] value);
        issue(make_uop(rv_ex_pkg::UOP_ALU, rv_ex_pkg::ALU_ADD, rv_ex_pkg::BR_BEQ,
                       rd, 5'd0, 5'd0, 1'b1, value));
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        do begin
            issue('0);
            n++;
        end while ((wb.valid || redirect.valid) && n < 8);
        if (wb.valid || redirect.valid) begin
            $display("Outputs still active 8 cycles after the last micro-op");
            errors++;
        end
    endtask

    // ======================================================================
    // Directed tests
    // ======================================================================

    task automatic reset_then_add();
        wait_idle();
        issue(make_uop(rv_ex_pkg::UOP_ALU, rv_ex_pkg::ALU_ADD, rv_ex_pkg::BR_BEQ,
                       5'd1, 5'd0, 5'd0, 1'b0, 32'd0));
        wait_idle();
    endtask

    task automatic alu_ops_all_forms();
        rv_ex_pkg::t_alu_op op;
        for (int r = 1; r < 8; r++) begin
            load_reg(5'(r), next_rand());
        end
        for (int i = 0; i < 10; i++) begin
            op = rv_ex_pkg::t_alu_op'(4'(i));
            issue(make_uop(rv_ex_pkg::UOP_ALU, op, rv_ex_pkg::BR_BEQ, 5'd10,
                           5'(next_rand() % 7 + 1), 5'(next_rand() % 7 + 1), 1'b0, 32'd0));
            issue(make_uop(rv_ex_pkg::UOP_ALU, op, rv_ex_pkg::BR_BEQ, 5'd11,
                           5'(next_rand() % 7 + 1), 5'd0, 1'b1, next_rand()));
        end
        wait_idle();
    endtask

    // Each step reads the register written the cycle before
    task automatic dependent_chain();
        logic [4:0] prev;
        prev = 5'd1;
        for (int i = 0; i < 8; i++) begin
            issue(make_uop(rv_ex_pkg::UOP_ALU, rv_ex_pkg::t_alu_op'(4'(next_rand() % 10)),
                           rv_ex_pkg::BR_BEQ, 5'(16 + i), prev, 5'(next_rand() % 7 + 1),
                           1'(i), next_rand()));
            prev = 5'(16 + i);
        end
        wait_idle();
    endtask

    task automatic branch_conditions();
        rv_ex_pkg::t_br_funct3 codes [6];
        int pa [5];
        int pb [5];
        codes = '{rv_ex_pkg::BR_BEQ, rv_ex_pkg::BR_BNE, rv_ex_pkg::BR_BLT,
                  rv_ex_pkg::BR_BGE, rv_ex_pkg::BR_BLTU, rv_ex_pkg::BR_BGEU};
        // Equal, less, greater, and a pair that differs only in sign
        pa = '{20, 20, 22, 23, 20};
        pb = '{21, 22, 20, 20, 23};
        load_reg(5'd20, 32'd5);
        load_reg(5'd21, 32'd5);
        load_reg(5'd22, 32'd7);
        load_reg(5'd23, 32'hFFFF_FFFB);
        for (int f = 0; f < 6; f++) begin
            for (int j = 0; j < 5; j++) begin
                issue(make_uop(rv_ex_pkg::UOP_BR, rv_ex_pkg::ALU_ADD, codes[f], 5'd0,
                               5'(pa[j]), 5'(pb[j]), 1'b0, 32'h0000_0040));
                issue('0);
            end
        end
        wait_idle();
    endtask

    task automatic squash_after_mispredict();
        rv_ex_pkg::t_uinstr br;
        br = make_uop(rv_ex_pkg::UOP_BR, rv_ex_pkg::ALU_ADD, rv_ex_pkg::BR_BEQ, 5'd0,
                      5'd20, 5'd21, 1'b0, 32'h0000_0080);
        load_reg(5'd25, 32'd100);
        issue(br);
        load_reg(5'd25, 32'd999);
        issue(make_uop(rv_ex_pkg::UOP_ALU, rv_ex_pkg::ALU_ADD, rv_ex_pkg::BR_BEQ,
                       5'd26, 5'd25, 5'd0, 1'b1, 32'd1));
        wait_idle();
        issue(br);
        issue(br);
        wait_idle();
    endtask

    task automatic x0_and_idle();
        rv_ex_pkg::t_uinstr u;
        issue(make_uop(rv_ex_pkg::UOP_ALU, rv_ex_pkg::ALU_ADD, rv_ex_pkg::BR_BEQ,
                       5'd0, 5'd1, 5'd0, 1'b1, 32'h1234_5678));
        issue(make_uop(rv_ex_pkg::UOP_ALU, rv_ex_pkg::ALU_OR, rv_ex_pkg::BR_BEQ,
                       5'd27, 5'd0, 5'd0, 1'b0, 32'd0));
        u = make_uop(rv_ex_pkg::UOP_ALU, rv_ex_pkg::ALU_XOR, rv_ex_pkg::BR_BEQ,
                     5'd28, 5'd1, 5'd2, 1'b0, 32'd0);
        u.valid = 1'b0;
        issue(u);
        u = make_uop(rv_ex_pkg::UOP_BR, rv_ex_pkg::ALU_ADD, rv_ex_pkg::BR_BNE,
                     5'd0, 5'd20, 5'd22, 1'b0, 32'h0000_0100);
        u.valid = 1'b0;
        issue(u);
        wait_idle();
    endtask

    initial begin
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = 32'd0;
        end
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        reset_then_add();
        alu_ops_all_forms();
        dependent_chain();
        branch_conditions();
        squash_after_mispredict();
        x0_and_idle();
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: rv_ex_top.sv
`timescale 1ns/1ns

module rv_ex_top #(
    parameter int num_regs = 32
) (
    input  logic                 clk,
    input  logic                 rst,
    input  rv_ex_pkg::t_uinstr   uinstr,
    output rv_ex_pkg::t_wb       wb,
    output rv_ex_pkg::t_redirect redirect
);

    rv_ex_pkg::t_reg_data src1;
    rv_ex_pkg::t_reg_data src2;
    rv_ex_pkg::t_reg_data alu_result;

    logic                 br_resvld;
    rv_ex_pkg::t_paddr    br_tgt;
    logic                 br_mispred;

    // Register file write port from retire
    logic                 rf_we;
    rv_ex_pkg::t_reg_idx  rf_wa;
    rv_ex_pkg::t_reg_data rf_wd;

    rv_regfile #(
        .num_regs (num_regs)
    ) rv_regfile_inst (
        .clk  (clk),
        .rst  (rst),
        .rs1  (uinstr.rs1),
        .rs2  (uinstr.rs2),
        .src1 (src1),
        .src2 (src2),
        .we   (rf_we),
        .wa   (rf_wa),
        .wd   (rf_wd)
    );

    rv_alu rv_alu_inst (
        .uinstr     (uinstr),
        .src1       (src1),
        .src2       (src2),
        .alu_result (alu_result)
    );

    rv_branch_unit rv_branch_unit_inst (
        .uinstr     (uinstr),
        .src1       (src1),
        .src2       (src2),
        .br_resvld  (br_resvld),
        .br_tgt     (br_tgt),
        .br_mispred (br_mispred)
    );

    rv_ex_retire rv_ex_retire_inst (
        .clk        (clk),
        .rst        (rst),
        .uinstr     (uinstr),
        .alu_result (alu_result),
        .br_resvld  (br_resvld),
        .br_mispred (br_mispred),
        .br_tgt     (br_tgt),
        .we         (rf_we),
        .wa         (rf_wa),
        .wd         (rf_wd),
        .wb         (wb),
        .redirect   (redirect)
    );

endmodule

// File: rv_regfile.sv
`timescale 1ns/1ns

module rv_regfile #(
    parameter int num_regs = 32
) (
    input  logic                clk,
    input  logic                rst,

    input  rv_ex_pkg::t_reg_idx  rs1,
    input  rv_ex_pkg::t_reg_idx  rs2,
    output rv_ex_pkg::t_reg_data src1,
    output rv_ex_pkg::t_reg_data src2,

    input  logic                we,
    input  rv_ex_pkg::t_reg_idx  wa,
    input  rv_ex_pkg::t_reg_data wd
);

    rv_ex_pkg::t_reg_data regs [num_regs];

    // ======================================================================
    // Write port
    // ======================================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wa != '0) && (int'(wa) < num_regs)) begin
            regs[wa] <= wd;
        end
    end

    // ======================================================================
    // Read ports
    // ======================================================================

    // x0 and indices past the end read zero
    always_comb begin
        src1 = '0;
        if ((rs1 != '0) && (int'(rs1) < num_regs)) begin
            src1 = regs[rs1];
        end
    end

    always_comb begin
        src2 = '0;
        if ((rs2 != '0) && (int'(rs2) < num_regs)) begin
            src2 = regs[rs2];
        end
    end

endmodule
